//--- common/coreTypes.sv
package coreTypes;

	// Function unit select
	typedef enum logic [1:0]
	{
		unitAlu    = 2'd0,
		unitBranch = 2'd1,	// JAL, JALR and conditional branches
		unitMem    = 2'd2,	// Loads and stores
		unitMulDiv = 2'd3	// M extension, op carried in fn3
	} unitSelT;

	// ALU operations
	typedef enum logic [3:0]
	{
		aluAdd   = 4'd0,
		aluSub   = 4'd1,
		aluSll   = 4'd2,
		aluSlt   = 4'd3,
		aluSltu  = 4'd4,
		aluXor   = 4'd5,
		aluSrl   = 4'd6,
		aluSra   = 4'd7,
		aluOr    = 4'd8,
		aluAnd   = 4'd9,
		aluPassB = 4'd10	// Operand B straight through, for LUI
	} aluFnT;

	// Memory access, size and sign
	typedef enum logic [3:0]
	{
		memNone = 4'd0,
		memLb   = 4'd1,
		memLh   = 4'd2,
		memLw   = 4'd3,
		memLbu  = 4'd4,
		memLhu  = 4'd5,
		memSb   = 4'd6,
		memSh   = 4'd7,
		memSw   = 4'd8
	} memOpT;

	// Immediate layout inside the word
	typedef enum logic [2:0]
	{
		immI    = 3'd0,
		immS    = 3'd1,
		immB    = 3'd2,
		immU    = 3'd3,
		immJ    = 3'd4,
		immNone = 3'd5	// R-type, immediate driven to zero
	} immFmtT;

endpackage

//--- common/core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// First fetch address out of reset
`define RESET_PC 32'h0000_0000

// Data and address width
`define XLEN 32

// RV32 major opcodes
`define OP_LUI    7'b0110111
`define OP_AUIPC  7'b0010111
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_BRANCH 7'b1100011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011

// Register-immediate ALU ops, shifts included
`define OP_IMM    7'b0010011

// Register-register ALU ops and the M extension
`define OP_REG    7'b0110011

`endif

//--- decode/decodeStage.sv
`timescale 1ns/10ps

`include "core_consts.svh"

module decodeStage
(
	input  logic                clk,
	input  logic                nrst,
	input  logic                redirectValid,	// Flush

	// From fetch
	input  logic                fetchValid,
	input  logic [`XLEN-1:0]    fetchPc,
	input  logic [31:0]         fetchInstr,
	output logic                fetchReady,

	// Toward issue
	output logic                outValid,
	input  logic                outReady,
	output logic [`XLEN-1:0]    pc,
	output logic [4:0]          rs1,
	output logic [4:0]          rs2,
	output logic [4:0]          rd,
	output logic [`XLEN-1:0]    imm,

	// Controls
	output coreTypes::unitSelT  unitSel,
	output coreTypes::aluFnT    aluFn,
	output coreTypes::memOpT    memOp,
	output logic [2:0]          fn3,
	output logic                opBImm,
	output logic                regWe,
	output logic                isBranch,
	output logic                isJal,
	output logic                isJalr,
	output logic                isAuipc,
	output logic                illegal
);

	import coreTypes::*;

	logic [31:0]      instrReg;
	logic [`XLEN-1:0] pcReg;
	logic             validReg;
	immFmtT           immFmt;	// From decoder

	// Take a new word when empty or when issue drains us
	assign fetchReady = !validReg || outReady;

	// Valid bit, flush has priority
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			validReg <= 1'b0;
		else if (redirectValid)
			validReg <= 1'b0;
		else if (fetchReady)
			validReg <= fetchValid;
		// Otherwise hold under back-pressure
	end

	// Instruction and pc registers
	always_ff @(posedge clk)
	begin
		if (fetchReady && fetchValid)
		begin
			instrReg <= fetchInstr;
			pcReg    <= fetchPc;
		end
	end

	assign outValid = validReg;
	assign pc       = pcReg;

	// Register fields
	assign rs1 = instrReg[19:15];
	assign rs2 = instrReg[24:20];
	assign rd  = instrReg[11:7];
	assign fn3 = instrReg[14:12];	// Branch cond, mem size or mulDiv op

	// One immediate, picked by format, always sign-extended
	// Shift amount sits in imm[4:0] for I-type shifts
	always_comb
	begin
		case (immFmt)
			immI: imm = {{20{instrReg[31]}}, instrReg[31:20]};
			immS: imm = {{20{instrReg[31]}}, instrReg[31:25], instrReg[11:7]};
			immB: imm = {{19{instrReg[31]}}, instrReg[31], instrReg[7],
				instrReg[30:25], instrReg[11:8], 1'b0};
			immU: imm = {instrReg[31:12], 12'b0};
			immJ: imm = {{11{instrReg[31]}}, instrReg[31], instrReg[19:12],
				instrReg[20], instrReg[30:21], 1'b0};
			default: imm = '0;	// R-type and illegal
		endcase
	end

	instrDecoder dec_i
	(
		.opcode   (instrReg[6:0]),
		.funct3   (instrReg[14:12]),
		.funct7   (instrReg[31:25]),
		.immFmt   (immFmt),
		.unitSel  (unitSel),
		.aluFn    (aluFn),
		.memOp    (memOp),
		.opBImm   (opBImm),
		.regWe    (regWe),
		.isBranch (isBranch),
		.isJal    (isJal),
		.isJalr   (isJalr),
		.isAuipc  (isAuipc),
		.illegal  (illegal)
	);

endmodule

//--- decode/instrDecoder.sv
`timescale 1ns/10ps

`include "core_consts.svh"

module instrDecoder
(
	input  logic [6:0]          opcode,
	input  logic [2:0]          funct3,
	input  logic [6:0]          funct7,
	output coreTypes::immFmtT   immFmt,
	output coreTypes::unitSelT  unitSel,
	output coreTypes::aluFnT    aluFn,
	output coreTypes::memOpT    memOp,
	output logic                opBImm,	// Operand B from immediate
	output logic                regWe,
	output logic                isBranch,
	output logic                isJal,
	output logic                isJalr,
	output logic                isAuipc,
	output logic                illegal
);

	import coreTypes::*;

	// ALU op for OP and OP-IMM with alt taken from instr[30]
	function automatic aluFnT aluFromF3(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: aluFromF3 = alt ? aluSub : aluAdd;
			3'b001: aluFromF3 = aluSll;
			3'b010: aluFromF3 = aluSlt;
			3'b011: aluFromF3 = aluSltu;
			3'b100: aluFromF3 = aluXor;
			3'b101: aluFromF3 = alt ? aluSra : aluSrl;
			3'b110: aluFromF3 = aluOr;
			default: aluFromF3 = aluAnd;
		endcase
	endfunction

	always_comb
	begin
		immFmt   = immNone;
		unitSel  = unitAlu;
		aluFn    = aluAdd;
		memOp    = memNone;
		opBImm   = 1'b0;
		regWe    = 1'b0;
		isBranch = 1'b0;
		isJal    = 1'b0;
		isJalr   = 1'b0;
		isAuipc  = 1'b0;
		illegal  = 1'b0;

		case (opcode)
			`OP_LUI:
			begin
				immFmt = immU;
				aluFn  = aluPassB;
				opBImm = 1'b1;
				regWe  = 1'b1;
			end
			`OP_AUIPC:
			begin
				immFmt  = immU;
				opBImm  = 1'b1;
				regWe   = 1'b1;
				isAuipc = 1'b1;
			end
			`OP_JAL:
			begin
				immFmt  = immJ;
				unitSel = unitBranch;
				opBImm  = 1'b1;
				regWe   = 1'b1;
				isJal   = 1'b1;
			end
			`OP_JALR:
			begin
				immFmt  = immI;
				unitSel = unitBranch;
				opBImm  = 1'b1;
				regWe   = 1'b1;
				isJalr  = 1'b1;
				illegal = (funct3 != 3'b000);
			end
			`OP_BRANCH:
			begin
				immFmt   = immB;
				unitSel  = unitBranch;
				isBranch = 1'b1;
				// Compare op while the condition itself rides on fn3
				aluFn = funct3[2] ? (funct3[1] ? aluSltu : aluSlt) : aluSub;
				illegal = (funct3[2:1] == 2'b01);	// 010 and 011 unused
			end
			`OP_LOAD:
			begin
				immFmt  = immI;
				unitSel = unitMem;
				opBImm  = 1'b1;
				regWe   = 1'b1;
				case (funct3)
					3'b000: memOp = memLb;
					3'b001: memOp = memLh;
					3'b010: memOp = memLw;
					3'b100: memOp = memLbu;
					3'b101: memOp = memLhu;
					default: illegal = 1'b1;
				endcase
			end
			`OP_STORE:
			begin
				immFmt  = immS;
				unitSel = unitMem;
				opBImm  = 1'b1;
				case (funct3)
					3'b000: memOp = memSb;
					3'b001: memOp = memSh;
					3'b010: memOp = memSw;
					default: illegal = 1'b1;
				endcase
			end
			`OP_IMM:
			begin
				immFmt = immI;
				opBImm = 1'b1;
				regWe  = 1'b1;
				// No SUBI since funct7 only matters for shifts
				aluFn = aluFromF3(funct3, (funct3 == 3'b101) && funct7[5]);
				if (funct3 == 3'b001)
					illegal = (funct7 != 7'b0000000);
				else if (funct3 == 3'b101)
					illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
			end
			`OP_REG:
			begin
				regWe = 1'b1;
				if (funct7 == 7'b0000001)
					unitSel = unitMulDiv;	// MUL..REMU with every funct3 valid
				else if (funct7 == 7'b0000000)
					aluFn = aluFromF3(funct3, 1'b0);
				else if (funct7 == 7'b0100000)
				begin
					aluFn = aluFromF3(funct3, 1'b1);
					illegal = (funct3 != 3'b000) && (funct3 != 3'b101);	// Only SUB and SRA
				end
				else
					illegal = 1'b1;
			end
			default: illegal = 1'b1;	// CSR, FENCE and unknown opcodes
		endcase

		// Illegal word does nothing downstream
		if (illegal)
		begin
			immFmt   = immNone;
			unitSel  = unitAlu;
			aluFn    = aluAdd;
			memOp    = memNone;
			opBImm   = 1'b0;
			regWe    = 1'b0;
			isBranch = 1'b0;
			isJal    = 1'b0;
			isJalr   = 1'b0;
			isAuipc  = 1'b0;
		end
	end

endmodule

//--- hw/fetchStage.sv
`timescale 1ns/10ps

`include "core_consts.svh"

module fetchStage
(
	input  logic              clk,
	input  logic              nrst,

	// Redirect from execute
	input  logic              redirectValid,
	input  logic [`XLEN-1:0]  redirectPc,

	// Instruction memory, combinational read
	output logic [`XLEN-1:0]  imemAddr,
	input  logic [`XLEN-1:0]  imemData,

	// Toward decode
	output logic              fetchValid,
	output logic [`XLEN-1:0]  fetchPc,
	output logic [31:0]       fetchInstr,
	input  logic              fetchReady
);

	logic [`XLEN-1:0] pcReg;	// Next address to fetch
	logic             loadSlot;

	// Slot empty or being taken this edge
	assign loadSlot = !fetchValid || fetchReady;

	assign imemAddr = pcReg;	// Word comes back same cycle

	// PC and slot valid
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			pcReg      <= `RESET_PC;
			fetchValid <= 1'b0;
		end
		else if (redirectValid)
		begin
			// Drop the slot, restart at the target
			pcReg      <= redirectPc;
			fetchValid <= 1'b0;
		end
		else if (loadSlot)
		begin
			pcReg      <= pcReg + `XLEN'd4;
			fetchValid <= 1'b1;
		end
	end

	// Slot payload
	always_ff @(posedge clk)
	begin
		if (loadSlot && !redirectValid)
		begin
			fetchPc    <= pcReg;
			fetchInstr <= imemData;
		end
	end

endmodule

//--- hw/frontEnd.sv
`timescale 1ns/10ps

`include "core_consts.svh"

module frontEnd
(
	input  logic                clk,
	input  logic                nrst,

	// Instruction memory
	output logic [`XLEN-1:0]    imemAddr,
	input  logic [`XLEN-1:0]    imemData,

	// Redirect from execute
	input  logic                redirectValid,
	input  logic [`XLEN-1:0]    redirectPc,

	// Decoded instruction toward issue
	output logic                outValid,
	input  logic                outReady,
	output logic [`XLEN-1:0]    pc,
	output logic [4:0]          rs1,
	output logic [4:0]          rs2,
	output logic [4:0]          rd,
	output logic [`XLEN-1:0]    imm,
	output coreTypes::unitSelT  unitSel,
	output coreTypes::aluFnT    aluFn,
	output coreTypes::memOpT    memOp,
	output logic [2:0]          fn3,
	output logic                opBImm,
	output logic                regWe,
	output logic                isBranch,
	output logic                isJal,
	output logic                isJalr,
	output logic                isAuipc,
	output logic                illegal
);

	// Fetch to decode handshake
	logic             fetchValid;
	logic             fetchReady;
	logic [`XLEN-1:0] fetchPc;
	logic [31:0]      fetchInstr;

	fetchStage fetch_i
	(
		.clk           (clk),
		.nrst          (nrst),
		.redirectValid (redirectValid),
		.redirectPc    (redirectPc),
		.imemAddr      (imemAddr),
		.imemData      (imemData),
		.fetchValid    (fetchValid),
		.fetchPc       (fetchPc),
		.fetchInstr    (fetchInstr),
		.fetchReady    (fetchReady)
	);

	// Same redirect flushes decode too
	decodeStage decode_i
	(
		.clk           (clk),
		.nrst          (nrst),
		.redirectValid (redirectValid),
		.fetchValid    (fetchValid),
		.fetchPc       (fetchPc),
		.fetchInstr    (fetchInstr),
		.fetchReady    (fetchReady),
		.outValid      (outValid),
		.outReady      (outReady),
		.pc            (pc),
		.rs1           (rs1),
		.rs2           (rs2),
		.rd            (rd),
		.imm           (imm),
		.unitSel       (unitSel),
		.aluFn         (aluFn),
		.memOp         (memOp),
		.fn3           (fn3),
		.opBImm        (opBImm),
		.regWe         (regWe),
		.isBranch      (isBranch),
		.isJal         (isJal),
		.isJalr        (isJalr),
		.isAuipc       (isAuipc),
		.illegal       (illegal)
	);

endmodule

//--- sim/frontEndTb.sv
`timescale 1ns/10ps

`include "core_consts.svh"

module frontEndTb;

	import coreTypes::*;

	localparam int clkPeriod   = 20;
	localparam int runCycles   = 2000;	// Random phase length
	localparam int totalCycles = 5 + 40 + runCycles + 20;

	// Expected decode of one word
	typedef struct packed
	{
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [4:0]  rd;
		logic [31:0] imm;
		unitSelT     unitSel;
		aluFnT       aluFn;
		memOpT       memOp;
		logic [2:0]  fn3;
		logic        opBImm;
		logic        regWe;
		logic        isBranch;
		logic        isJal;
		logic        isJalr;
		logic        isAuipc;
		logic        illegal;
	} expT;

	logic        clk;
	logic        nrst;
	logic [31:0] imemAddr;
	logic [31:0] imemData;
	logic        redirectValid;
	logic [31:0] redirectPc;
	logic        outValid;
	logic        outReady;
	logic [31:0] pc;
	logic [4:0]  rs1;
	logic [4:0]  rs2;
	logic [4:0]  rd;
	logic [31:0] imm;
	unitSelT     unitSel;
	aluFnT       aluFn;
	memOpT       memOp;
	logic [2:0]  fn3;
	logic        opBImm;
	logic        regWe;
	logic        isBranch;
	logic        isJal;
	logic        isJalr;
	logic        isAuipc;
	logic        illegal;

	logic [31:0] rom [256];
	logic [31:0] expPcQ [$];	// Next pc the stream must show
	logic [99:0] curBus;
	logic [99:0] heldBus;
	logic        holdPending;
	logic [31:0] expP;
	expT         expFields;
	logic [3:0]  seenUnit;
	logic        sawIllegal;
	int          xferCount;
	int          sinceRst;
	int          stallLeft;
	int          target;

	// OP and OP-IMM base ops by funct3
	aluFnT       aluTab [8] = '{aluAdd, aluSll, aluSlt, aluSltu, aluXor, aluSrl, aluOr, aluAnd};
	logic [2:0]  loadF3 [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
	logic [6:0]  badOps [3] = '{7'b1110011, 7'b0001111, 7'b1111111};	// CSR, FENCE and unused

	frontEnd dut_i
	(
		.clk           (clk),
		.nrst          (nrst),
		.imemAddr      (imemAddr),
		.imemData      (imemData),
		.redirectValid (redirectValid),
		.redirectPc    (redirectPc),
		.outValid      (outValid),
		.outReady      (outReady),
		.pc            (pc),
		.rs1           (rs1),
		.rs2           (rs2),
		.rd            (rd),
		.imm           (imm),
		.unitSel       (unitSel),
		.aluFn         (aluFn),
		.memOp         (memOp),
		.fn3           (fn3),
		.opBImm        (opBImm),
		.regWe         (regWe),
		.isBranch      (isBranch),
		.isJal         (isJal),
		.isJalr        (isJalr),
		.isAuipc       (isAuipc),
		.illegal       (illegal)
	);

	assign imemData = rom[imemAddr[9:2]];	// Combinational ROM that wraps every 1 KB
	assign curBus = {outValid, pc, rs1, rs2, rd, imm, unitSel, aluFn, memOp, fn3,
		opBImm, regWe, isBranch, isJal, isJalr, isAuipc, illegal};

	task automatic reportFail(input string msg);
		$display("%s", msg);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic checkField(input string name, input logic [31:0] expV,
		input logic [31:0] actV);
		assert (actV === expV)
		else
			reportFail($sformatf("MISMATCH time=%0t signal=%s expected=%h actual=%h",
				$time, name, expV, actV));
	endtask

	// One random word of the given class
	function automatic logic [31:0] randWord(input int kind);
		logic [31:0] r;
		logic [2:0]  f3;
		logic [2:0]  st;
		r  = $urandom;
		f3 = r[14:12];
		st = $urandom % 3;
		case (kind)
			0: return {r[31:7], `OP_LUI};
			1: return {r[31:7], `OP_AUIPC};
			2: return {r[31:7], `OP_JAL};
			3: return {r[31:15], 3'b000, r[11:7], `OP_JALR};
			4: return {r[31:15], f3[2] | f3[1], f3[1:0], r[11:7], `OP_BRANCH};	// Skips 010 and 011
			5: return {r[31:15], loadF3[$urandom % 5], r[11:7], `OP_LOAD};
			6: return {r[31:15], st, r[11:7], `OP_STORE};
			7:
			begin
				if (f3 == 3'b001)
					return {7'b0000000, r[24:15], f3, r[11:7], `OP_IMM};
				if (f3 == 3'b101)
					return {1'b0, r[30], 5'b00000, r[24:15], f3, r[11:7], `OP_IMM};
				return {r[31:15], f3, r[11:7], `OP_IMM};
			end
			8: return {1'b0, r[30] && (f3 == 3'b000 || f3 == 3'b101), 5'b00000,
				r[24:15], f3, r[11:7], `OP_REG};
			9: return {7'b0000001, r[24:15], f3, r[11:7], `OP_REG};	// M extension
			10: return {r[31:7], badOps[$urandom % 3]};
			default: return {1'b1, r[30:15], f3, r[11:7], `OP_REG};	// funct7 undefined
		endcase
	endfunction

	// Expected fields straight from the RV32IM encoding rules
	function automatic expT refDecode(input logic [31:0] w);
		expT         e;
		logic [6:0]  op;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic        legal;
		logic [31:0] iImm;
		logic [31:0] sImm;
		logic [31:0] bImm;
		logic [31:0] jImm;
		op    = w[6:0];
		f3    = w[14:12];
		f7    = w[31:25];
		legal = 1'b1;
		iImm  = $signed(w[31:20]);
		sImm  = $signed({w[31:25], w[11:7]});
		bImm  = $signed({w[31], w[7], w[30:25], w[11:8], 1'b0});
		jImm  = $signed({w[31], w[19:12], w[20], w[30:21], 1'b0});
		e     = '0;
		case (op)
			`OP_LUI:
			begin
				e.imm   = {w[31:12], 12'h000};
				e.aluFn = aluPassB;
			end
			`OP_AUIPC:
			begin
				e.imm     = {w[31:12], 12'h000};
				e.isAuipc = 1'b1;
			end
			`OP_JAL:
			begin
				e.imm     = jImm;
				e.unitSel = unitBranch;
				e.isJal   = 1'b1;
			end
			`OP_JALR:
			begin
				e.imm     = iImm;
				e.unitSel = unitBranch;
				e.isJalr  = 1'b1;
				legal     = (f3 == 3'b000);
			end
			`OP_BRANCH:
			begin
				e.imm      = bImm;
				e.unitSel  = unitBranch;
				e.isBranch = 1'b1;
				e.aluFn    = !f3[2] ? aluSub : (f3[1] ? aluSltu : aluSlt);	// EQ/NE vs LT/LTU
				legal      = (f3 != 3'b010) && (f3 != 3'b011);
			end
			`OP_LOAD:
			begin
				e.imm     = iImm;
				e.unitSel = unitMem;
				case (f3)
					3'b000: e.memOp = memLb;
					3'b001: e.memOp = memLh;
					3'b010: e.memOp = memLw;
					3'b100: e.memOp = memLbu;
					3'b101: e.memOp = memLhu;
					default: legal = 1'b0;
				endcase
			end
			`OP_STORE:
			begin
				e.imm     = sImm;
				e.unitSel = unitMem;
				if (f3 == 3'b000)
					e.memOp = memSb;
				else if (f3 == 3'b001)
					e.memOp = memSh;
				else if (f3 == 3'b010)
					e.memOp = memSw;
				else
					legal = 1'b0;
			end
			`OP_IMM:
			begin
				e.imm   = iImm;
				e.aluFn = aluTab[f3];
				if (f3 == 3'b001)
					legal = (f7 == 7'b0000000);
				else if (f3 == 3'b101)
				begin
					legal = (f7 == 7'b0000000) || (f7 == 7'b0100000);
					if (f7[5])
						e.aluFn = aluSra;
				end
			end
			`OP_REG:
			begin
				if (f7 == 7'b0000001)
					e.unitSel = unitMulDiv;
				else if (f7 == 7'b0000000)
					e.aluFn = aluTab[f3];
				else if (f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101))
					e.aluFn = (f3 == 3'b000) ? aluSub : aluSra;
				else
					legal = 1'b0;
			end
			default: legal = 1'b0;
		endcase
		e.opBImm = (op != `OP_BRANCH) && (op != `OP_REG);
		e.regWe  = (op != `OP_BRANCH) && (op != `OP_STORE);
		if (!legal)
			e = '0;	// Illegal word carries no controls
		e.rs1     = w[19:15];
		e.rs2     = w[24:20];
		e.rd      = w[11:7];
		e.fn3     = f3;
		e.illegal = !legal;
		return e;
	endfunction

	initial
	begin
		clk = 1'b0;
		forever
			#(clkPeriod / 2) clk = ~clk;
	end

	// Watchdog
	initial
	begin
		#(4 * totalCycles * clkPeriod);
		reportFail("Watchdog timeout, the run did not reach its end");
	end

	// Monitor and scoreboard on pre-edge values
	always @(posedge clk)
	begin
		if (!nrst)
		begin
			sinceRst = 0;
			expPcQ.delete();
			expPcQ.push_back(`RESET_PC);
			assert (!outValid) else reportFail("outValid high while in reset");
		end
		else
		begin
			sinceRst = sinceRst + 1;
			if (sinceRst <= 2)
				assert (!outValid)
				else
					reportFail("outValid high right after the first edge out of reset");
			if (sinceRst == 3)
				assert (outValid)
				else
					reportFail("outValid still low two cycles after reset release");
			if (holdPending)
				assert (curBus === heldBus)
				else
					reportFail($sformatf(
						"MISMATCH time=%0t signal=held outputs expected=%h actual=%h",
						$time, heldBus, curBus));
			if (outValid && outReady)
			begin
				expP = expPcQ.pop_front();
				expPcQ.push_back(expP + 32'd4);
				expFields = refDecode(rom[expP[9:2]]);
				checkField("pc", expP, pc);
				checkField("rs1", expFields.rs1, rs1);
				checkField("rs2", expFields.rs2, rs2);
				checkField("rd", expFields.rd, rd);
				checkField("imm", expFields.imm, imm);
				checkField("unitSel", expFields.unitSel, unitSel);
				checkField("aluFn", expFields.aluFn, aluFn);
				checkField("memOp", expFields.memOp, memOp);
				checkField("fn3", expFields.fn3, fn3);
				checkField("opBImm", expFields.opBImm, opBImm);
				checkField("regWe", expFields.regWe, regWe);
				checkField("isBranch", expFields.isBranch, isBranch);
				checkField("isJal", expFields.isJal, isJal);
				checkField("isJalr", expFields.isJalr, isJalr);
				checkField("isAuipc", expFields.isAuipc, isAuipc);
				checkField("illegal", expFields.illegal, illegal);
				seenUnit[unitSel] = 1'b1;
				sawIllegal = sawIllegal | illegal;
				xferCount <= xferCount + 1;
			end
			if (redirectValid)
			begin
				// Stream restarts at the target
				expPcQ.delete();
				expPcQ.push_back(redirectPc);
			end
			holdPending = outValid && !outReady && !redirectValid;
			heldBus = curBus;
		end
	end

	// Stimulus
	initial
	begin
		void'($urandom(75683));
		for (int i = 0; i < 256; i++)
			rom[i] = randWord((i < 12) ? i : $urandom % 12);	// Every class at least once
		nrst          = 1'b0;
		outReady      = 1'b0;
		redirectValid = 1'b0;
		redirectPc    = '0;
		holdPending   = 1'b0;
		seenUnit      = '0;
		sawIllegal    = 1'b0;
		xferCount     = 0;
		stallLeft     = 0;
		repeat (5) @(posedge clk);
		nrst     <= 1'b1;
		outReady <= 1'b1;
		while (xferCount < 20)	// Straight run from reset pc
			@(posedge clk);
		for (int c = 0; c < runCycles; c++)
		begin
			@(posedge clk);
			if (stallLeft > 0)
			begin
				outReady <= 1'b0;
				stallLeft--;
			end
			else if ($urandom % 16 == 0)
			begin
				stallLeft = 2 + $urandom % 6;	// Back-pressure burst
				outReady <= 1'b0;
			end
			else
				outReady <= ($urandom % 4 != 0);
			redirectValid <= ($urandom % 24 == 0);	// Also lands inside stalls
			redirectPc    <= ($urandom % 256) * 4;
		end
		@(posedge clk);
		outReady      <= 1'b1;
		redirectValid <= 1'b0;
		target = xferCount + 3;
		while (xferCount < target)
			@(posedge clk);
		if (xferCount >= runCycles / 4 && (&seenUnit) && sawIllegal)
		begin
			$display("Regression passed");
			$finish;
		end
		else
			reportFail("Too few transfers or an instruction class never reached the output");
	end

endmodule

//--- vlog.f
+incdir+common
common/coreTypes.sv
hw/fetchStage.sv
decode/instrDecoder.sv
decode/decodeStage.sv
hw/frontEnd.sv
sim/frontEndTb.sv
